//--- files.f
+incdir+src
src/mem_pkg.sv
src/ctrl_pkg.sv
src/mem_if.sv
src/bram_sp.sv
src/mem_arbiter.sv
src/axis_bram_writer.sv
src/axis_bram_reader.sv
src/sample_buffer_top.sv
test/tb_sample_buffer.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal --top-module tb_sample_buffer \
  -f files.f -o tb_sample_buffer \
  && { ./obj_dir/tb_sample_buffer 2>&1 | tee "$LOG"; true; } \
  && grep -qx "All tests passed" "$LOG" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- src/axis_bram_reader.sv
`timescale 1ns/1ps

module axis_bram_reader (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 play_enable,
  input  ctrl_pkg::play_mode_e play_mode,
  input  mem_pkg::mem_addr_t   play_last,
  output mem_pkg::mem_data_t   m_axis_tdata,
  output logic                 m_axis_tvalid,
  output logic                 m_axis_tlast,
  input  logic                 m_axis_tready,
  mem_if.client                mem
);

  mem_pkg::mem_addr_t addr_q;         // Next address to issue
  logic               active;         // Pass being issued
  logic               armed;          // Enable seen low since last start
  logic               inflight;       // Read granted last cycle
  logic               inflight_last;
  logic               issue;
  logic               issue_last;
  logic [1:0]         used;           // Buffer entries taken or promised

  mem_pkg::mem_data_t fifo_data [2];
  logic               fifo_last [2];
  logic               wr_ptr;
  logic               rd_ptr;
  logic [1:0]         fifo_count;
  logic               push;
  logic               pop;

  always_comb
  begin
    used       = fifo_count + {1'b0, inflight};
    issue      = mem.req && mem.gnt;
    issue_last = addr_q == play_last;
    push       = mem.rvalid;
    pop        = m_axis_tvalid && m_axis_tready;
  end

  // Read-only client
  assign mem.req   = active && (used < 2'd2);
  assign mem.we    = 1'b0;
  assign mem.addr  = addr_q;
  assign mem.wdata = '0;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      addr_q        <= '0;
      active        <= 1'b0;
      armed         <= 1'b0;
      inflight      <= 1'b0;
      inflight_last <= 1'b0;
    end
    else
    begin
      inflight <= issue;
      if (issue)
        inflight_last <= issue_last;
      if (!play_enable)
        armed <= 1'b1;
      if (!active && play_enable && armed)
      begin
        active <= 1'b1;
        armed  <= 1'b0;
      end
      else if (issue)
      begin
        if (issue_last)
        begin
          addr_q <= '0;
          active <= (play_mode == ctrl_pkg::PLAY_LOOP) && play_enable;  // Wrap or stop
        end
        else
        begin
          addr_q <= addr_q + 1'b1;
        end
      end
    end
  end

  // Two-entry output buffer
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr     <= 1'b0;
      rd_ptr     <= 1'b0;
      fifo_count <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr <= !wr_ptr;
      if (pop)
        rd_ptr <= !rd_ptr;
      case ({push, pop})
        2'b10:   fifo_count <= fifo_count + 2'd1;
        2'b01:   fifo_count <= fifo_count - 2'd1;
        default: fifo_count <= fifo_count;
      endcase
    end
  end

  always_ff @(posedge aclk)
  begin
    if (push)
    begin
      fifo_data[wr_ptr] <= mem.rdata;
      fifo_last[wr_ptr] <= inflight_last;
    end
  end

  assign m_axis_tvalid = fifo_count != 2'd0;
  assign m_axis_tdata  = fifo_data[rd_ptr];
  assign m_axis_tlast  = fifo_last[rd_ptr];

endmodule

//--- src/axis_bram_writer.sv
`timescale 1ns/1ps
`include "buf_defs.svh"

module axis_bram_writer (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  mem_pkg::mem_data_t    s_axis_tdata,
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  logic                  wr_clear,
  output ctrl_pkg::cap_status_t status,
  mem_if.client                 mem
);

  logic [`BUF_ADDR_W:0] count;  // Samples held and next address
  logic                 full;

  assign full = count == (`BUF_ADDR_W+1)'(`BUF_DEPTH);

  // Write request follows the stream directly
  assign mem.req   = s_axis_tvalid && !full;
  assign mem.we    = 1'b1;
  assign mem.addr  = count[`BUF_ADDR_W-1:0];
  assign mem.wdata = s_axis_tdata;

  assign s_axis_tready = mem.gnt;  // Only ever high with req

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      count <= '0;
    end
    else if (wr_clear)
    begin
      count <= '0;
    end
    else if (mem.req && mem.gnt)
    begin
      count <= count + 1'b1;
    end
  end

  assign status.wr_count = count;
  assign status.wr_full  = full;

endmodule

//--- src/bram_sp.sv
`timescale 1ns/1ps
`include "buf_defs.svh"

module bram_sp (
  input  logic               aclk,
  input  logic               en,
  input  logic               we,
  input  mem_pkg::mem_addr_t addr,
  input  mem_pkg::mem_data_t wdata,
  output mem_pkg::mem_data_t rdata
);

  mem_pkg::mem_data_t ram [`BUF_DEPTH];

  always_ff @(posedge aclk)
  begin
    if (en)
    begin
      if (we)
        ram[addr] <= wdata;
      rdata <= ram[addr];  // Read-first with data valid next cycle
    end
  end

endmodule

//--- src/buf_defs.svh
`ifndef BUF_DEFS_SVH
`define BUF_DEFS_SVH

// Sample word width
`define BUF_DATA_W 32

// RAM address width and word count
`define BUF_ADDR_W 8
`define BUF_DEPTH  256

`endif

//--- src/ctrl_pkg.sv
`include "buf_defs.svh"

package ctrl_pkg;

  typedef enum logic
  {
    PLAY_ONCE = 1'b0,  // Single pass per enable
    PLAY_LOOP = 1'b1   // Wrap while enabled
  } play_mode_e;

  // Capture fill state with a count one bit wider than an address
  typedef struct packed
  {
    logic [`BUF_ADDR_W:0] wr_count;
    logic                 wr_full;
  } cap_status_t;

endpackage

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic   aclk,
  input  logic   aresetn,
  mem_if.arbiter wr_port,
  mem_if.arbiter rd_port
);

  mem_pkg::owner_e    prio;        // Favoured client on contention
  mem_pkg::owner_e    rd_owner;    // Who issued the read in flight
  logic               rd_pending;
  logic               wr_win;
  logic               rd_win;
  logic               ram_en;
  logic               ram_we;
  mem_pkg::mem_addr_t ram_addr;
  mem_pkg::mem_data_t ram_wdata;
  mem_pkg::mem_data_t ram_rdata;

  always_comb
  begin
    wr_win    = wr_port.req && (!rd_port.req || prio == wr_port.OWNER);
    rd_win    = rd_port.req && (!wr_port.req || prio == rd_port.OWNER);
    ram_en    = wr_win || rd_win;
    ram_we    = wr_win ? wr_port.we : rd_port.we;
    ram_addr  = wr_win ? wr_port.addr : rd_port.addr;
    ram_wdata = wr_win ? wr_port.wdata : rd_port.wdata;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      prio       <= mem_pkg::OWN_WRITER;
      rd_owner   <= mem_pkg::OWN_WRITER;
      rd_pending <= 1'b0;
    end
    else
    begin
      if (wr_port.req && rd_port.req)
        prio <= wr_win ? rd_port.OWNER : wr_port.OWNER;  // Loser goes first next time
      rd_pending <= ram_en && !ram_we;
      rd_owner   <= wr_win ? wr_port.OWNER : rd_port.OWNER;
    end
  end

  assign wr_port.gnt    = wr_win;
  assign rd_port.gnt    = rd_win;
  assign wr_port.rdata  = ram_rdata;
  assign rd_port.rdata  = ram_rdata;
  assign wr_port.rvalid = rd_pending && (rd_owner == wr_port.OWNER);
  assign rd_port.rvalid = rd_pending && (rd_owner == rd_port.OWNER);

  bram_sp bram_sp_i (
    .aclk  (aclk),
    .en    (ram_en),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

endmodule

//--- src/mem_if.sv
`timescale 1ns/1ps

interface mem_if #(
  parameter mem_pkg::owner_e OWNER = mem_pkg::OWN_WRITER  // Identity seen by the arbiter
) ();

  logic               req;     // Held with fields stable until gnt
  logic               we;
  mem_pkg::mem_addr_t addr;
  mem_pkg::mem_data_t wdata;

  logic               gnt;     // Access happens on req and gnt
  mem_pkg::mem_data_t rdata;
  logic               rvalid;  // One cycle after a granted read

  modport client
  (
    output req, we, addr, wdata,
    input  gnt, rdata, rvalid
  );

  modport arbiter
  (
    input  req, we, addr, wdata,
    output gnt, rdata, rvalid
  );

endinterface

//--- src/mem_pkg.sv
`include "buf_defs.svh"

package mem_pkg;

  // One RAM address
  typedef logic [`BUF_ADDR_W-1:0] mem_addr_t;

  // One RAM word
  typedef logic [`BUF_DATA_W-1:0] mem_data_t;

  // Client identity on the shared RAM port
  typedef enum logic
  {
    OWN_WRITER = 1'b0,
    OWN_READER = 1'b1
  } owner_e;

endpackage

//--- src/sample_buffer_top.sv
`timescale 1ns/1ps
`include "buf_defs.svh"

module sample_buffer_top (
  input  logic                 aclk,
  input  logic                 aresetn,

  // Capture stream
  input  mem_pkg::mem_data_t   s_axis_tdata,
  input  logic                 s_axis_tvalid,
  output logic                 s_axis_tready,

  // Playback stream
  output mem_pkg::mem_data_t   m_axis_tdata,
  output logic                 m_axis_tvalid,
  input  logic                 m_axis_tready,
  output logic                 m_axis_tlast,

  input  logic                 wr_clear,     // Restart capture at address zero
  input  logic                 play_enable,
  input  ctrl_pkg::play_mode_e play_mode,
  input  mem_pkg::mem_addr_t   play_last,    // Last address of a pass
  output logic [`BUF_ADDR_W:0] wr_count,
  output logic                 wr_full
);

  ctrl_pkg::cap_status_t cap_status;

  mem_if #(.OWNER(mem_pkg::OWN_WRITER)) wr_mem ();
  mem_if #(.OWNER(mem_pkg::OWN_READER)) rd_mem ();

  axis_bram_writer axis_bram_writer_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .wr_clear      (wr_clear),
    .status        (cap_status),
    .mem           (wr_mem.client)
  );

  axis_bram_reader axis_bram_reader_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .play_enable   (play_enable),
    .play_mode     (play_mode),
    .play_last     (play_last),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready),
    .mem           (rd_mem.client)
  );

  // Shared RAM behind round-robin grant
  mem_arbiter mem_arbiter_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wr_port (wr_mem.arbiter),
    .rd_port (rd_mem.arbiter)
  );

  assign wr_count = cap_status.wr_count;
  assign wr_full  = cap_status.wr_full;

endmodule

//--- test/tb_sample_buffer.sv
`timescale 1ns/1ps
`include "buf_defs.svh"

module tb_sample_buffer;

  typedef enum int
  {
    K_CAPTURE,
    K_PLAY,
    K_FILL_CLEAR,
    K_CONCURRENT
  } row_kind_e;

  typedef struct
  {
    string                name;
    row_kind_e            kind;
    ctrl_pkg::play_mode_e mode;
    mem_pkg::mem_addr_t   last;   // play_last for playback rows
    int                   count;  // Samples to capture
    bit                   bp;     // Random stalls on the stream
  } test_row_t;

  localparam int NUM_ROWS   = 7;
  localparam int WAIT_LIMIT = 200;

  logic                 aclk;
  logic                 aresetn;
  mem_pkg::mem_data_t   s_axis_tdata;
  logic                 s_axis_tvalid;
  logic                 s_axis_tready;
  mem_pkg::mem_data_t   m_axis_tdata;
  logic                 m_axis_tvalid;
  logic                 m_axis_tready;
  logic                 m_axis_tlast;
  logic                 wr_clear;
  logic                 play_enable;
  ctrl_pkg::play_mode_e play_mode;
  mem_pkg::mem_addr_t   play_last;
  logic [`BUF_ADDR_W:0] wr_count;
  logic                 wr_full;

  mem_pkg::mem_data_t model [`BUF_DEPTH];  // Expected RAM contents
  int                 wr_exp;              // Expected fill count
  logic [31:0]        rng_data;
  logic [31:0]        rng_ready;
  test_row_t          rows [NUM_ROWS];

  sample_buffer_top sample_buffer_top_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .wr_clear      (wr_clear),
    .play_enable   (play_enable),
    .play_mode     (play_mode),
    .play_last     (play_last),
    .wr_count      (wr_count),
    .wr_full       (wr_full)
  );

  initial
  begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout: %s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge aclk);
    #1;
  endtask

  // Outputs are sampled at the falling edge and hold to the next rise
  task automatic send_samples(input string name, input int n, input bit gaps);
    int sent;
    int stall;
    bit taken;
    sent  = 0;
    stall = 0;
    while (sent < n)
    begin
      if (!s_axis_tvalid)
      begin
        rng_data = xorshift32(rng_data);
        if (!gaps || rng_data[2:1] != 2'b00)
        begin
          s_axis_tvalid = 1'b1;
          s_axis_tdata  = rng_data;
        end
      end
      @(negedge aclk);
      taken = s_axis_tvalid && s_axis_tready;
      if (taken)
      begin
        model[wr_exp % `BUF_DEPTH] = s_axis_tdata;
        wr_exp++;
        sent++;
        stall = 0;
      end
      else if (s_axis_tvalid)
      begin
        stall++;
        if (stall > WAIT_LIMIT)
          timeout_fail({name, ": sample was never accepted on s_axis"});
      end
      next_cycle();
      if (taken)
        s_axis_tvalid = 1'b0;
    end
  endtask

  task automatic receive_pass(input string name, input mem_pkg::mem_addr_t last,
                              input bit bp);
    int idx;
    int idle;
    bit done;
    idx  = 0;
    idle = 0;
    done = 1'b0;
    while (!done)
    begin
      rng_ready     = xorshift32(rng_ready);
      m_axis_tready = bp ? rng_ready[0] : 1'b1;
      @(negedge aclk);
      if (m_axis_tvalid && m_axis_tready)
      begin
        check({name, " data"}, model[idx], m_axis_tdata);
        check({name, " tlast"}, 32'(idx == int'(last)), 32'(m_axis_tlast));
        done = (idx == int'(last));
        idx++;
        idle = 0;
      end
      else
      begin
        idle++;
        if (idle > WAIT_LIMIT)
          timeout_fail({name, ": playback word did not arrive on m_axis"});
      end
      next_cycle();
    end
  endtask

  task automatic expect_idle(input string name, input int cycles);
    m_axis_tready = 1'b1;
    repeat (cycles)
    begin
      @(negedge aclk);
      check({name, " idle tvalid"}, 32'd0, 32'(m_axis_tvalid));
      next_cycle();
    end
  endtask

  task automatic run_play(input test_row_t r);
    play_mode   = r.mode;
    play_last   = r.last;
    play_enable = 1'b1;
    receive_pass(r.name, r.last, r.bp);
    if (r.mode == ctrl_pkg::PLAY_LOOP)
    begin
      receive_pass({r.name, " pass 2"}, r.last, r.bp);
      play_enable = 1'b0;
      receive_pass({r.name, " drain"}, r.last, r.bp);  // Pass already started
    end
    expect_idle(r.name, 16);
    play_enable = 1'b0;
    next_cycle();
  endtask

  task automatic fill_and_clear(input test_row_t r);
    send_samples(r.name, `BUF_DEPTH - wr_exp, 1'b0);
    check({r.name, " wr_full"}, 32'd1, 32'(wr_full));
    check({r.name, " wr_count"}, `BUF_DEPTH, 32'(wr_count));
    s_axis_tvalid = 1'b1;
    s_axis_tdata  = xorshift32(rng_data);
    repeat (8)
    begin
      @(negedge aclk);
      check({r.name, " tready while full"}, 32'd0, 32'(s_axis_tready));
      next_cycle();
    end
    s_axis_tvalid = 1'b0;
    check({r.name, " wr_count held"}, `BUF_DEPTH, 32'(wr_count));
    wr_clear = 1'b1;
    next_cycle();
    wr_clear = 1'b0;
    check({r.name, " wr_count cleared"}, 32'd0, 32'(wr_count));
    check({r.name, " wr_full cleared"}, 32'd0, 32'(wr_full));
    wr_exp = 0;
    send_samples(r.name, r.count, 1'b1);  // Lands at address zero again
    check({r.name, " wr_count refill"}, 32'(wr_exp), 32'(wr_count));
  endtask

  task automatic run_concurrent(input test_row_t r);
    play_mode   = r.mode;
    play_last   = r.last;
    play_enable = 1'b1;
    fork
      send_samples({r.name, " capture"}, r.count, 1'b1);
      receive_pass({r.name, " playback"}, r.last, r.bp);
    join
    expect_idle(r.name, 16);
    play_enable = 1'b0;
    next_cycle();
    check({r.name, " wr_count"}, 32'(wr_exp), 32'(wr_count));
  endtask

  initial
  begin
    aresetn       = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b0;
    wr_clear      = 1'b0;
    play_enable   = 1'b0;
    play_mode     = ctrl_pkg::PLAY_ONCE;
    play_last     = '0;
    wr_exp        = 0;
    rng_data      = 32'd64550;
    rng_ready     = xorshift32(xorshift32(32'd64550));  // Two steps ahead on the same seed

    rows[0] = '{"capture", K_CAPTURE, ctrl_pkg::PLAY_ONCE, 8'd0, 64, 1'b1};
    rows[1] = '{"play_once", K_PLAY, ctrl_pkg::PLAY_ONCE, 8'd47, 0, 1'b0};
    rows[2] = '{"back_pressure", K_PLAY, ctrl_pkg::PLAY_ONCE, 8'd63, 0, 1'b1};
    rows[3] = '{"loop", K_PLAY, ctrl_pkg::PLAY_LOOP, 8'd9, 0, 1'b1};
    rows[4] = '{"full_clear", K_FILL_CLEAR, ctrl_pkg::PLAY_ONCE, 8'd0, 40, 1'b0};
    rows[5] = '{"replay", K_PLAY, ctrl_pkg::PLAY_ONCE, 8'd45, 0, 1'b1};
    rows[6] = '{"concurrent", K_CONCURRENT, ctrl_pkg::PLAY_ONCE, 8'd31, 100, 1'b1};

    repeat (8) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    @(negedge aclk);
    check("reset wr_count", 32'd0, 32'(wr_count));
    check("reset m_axis_tvalid", 32'd0, 32'(m_axis_tvalid));
    check("reset s_axis_tready", 32'd0, 32'(s_axis_tready));
    next_cycle();

    for (int i = 0; i < NUM_ROWS; i++)
    begin
      case (rows[i].kind)
        K_CAPTURE:
        begin
          send_samples(rows[i].name, rows[i].count, rows[i].bp);
          @(negedge aclk);
          check({rows[i].name, " tready idle"}, 32'd0, 32'(s_axis_tready));
          check({rows[i].name, " wr_count"}, 32'(wr_exp), 32'(wr_count));
          next_cycle();
        end
        K_PLAY:       run_play(rows[i]);
        K_FILL_CLEAR: fill_and_clear(rows[i]);
        default:      run_concurrent(rows[i]);
      endcase
    end

    $display("All tests passed");
    $finish;
  end

endmodule
